// File: rename_config.svh
/*
 * Rename stage configuration
 * Way count and register file sizes shared by the rename RTL
 */

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Instructions renamed and committed per cycle
`define RENAME_WAYS 2

// Physical register file size
`define RENAME_PREGS 64

// Architectural registers, fixed by the ISA
`define RENAME_AREGS 32

`endif

// File: rename_pkg.sv
/*
 * Rename package
 * Register index types and the reset mapping of the rename tables
 */

`include "rename_config.svh"

package rename_pkg;

    localparam int AREG_BITS = $clog2(`RENAME_AREGS);
    localparam int PREG_BITS = $clog2(`RENAME_PREGS);

    typedef logic [AREG_BITS-1:0] areg_t;   // Architectural register index
    typedef logic [PREG_BITS-1:0] preg_t;   // Physical register index

    // Out of reset every architectural register sits in the physical
    // register of the same number, so 0 to 31 are mapped and the rest free
    function automatic preg_t reset_preg(areg_t areg);
        return preg_t'(areg);
    endfunction

endpackage

// File: rename_map.sv
/*
 * Rename map
 * Speculative map (RAT) and retirement map (RRAT), with same-bundle
 * commit forwarding and one-cycle restore on an exception
 */

`include "rename_config.svh"

module rename_map (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 except,

    input  logic [`RENAME_WAYS-1:0]              rename_valid,
    input  logic [`RENAME_WAYS-1:0]              rename_grant,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] dest_areg,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] alloc_preg,

    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] src_a_areg,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] src_b_areg,

    input  logic [`RENAME_WAYS-1:0]              commit_valid,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] commit_areg,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] commit_preg,

    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_a_preg,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_b_preg,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] released_preg
);

    rename_pkg::preg_t [`RENAME_AREGS-1:0] spec_map;       // RAT
    rename_pkg::preg_t [`RENAME_AREGS-1:0] spec_map_next;
    rename_pkg::preg_t [`RENAME_AREGS-1:0] ret_map;        // RRAT
    rename_pkg::preg_t [`RENAME_AREGS-1:0] ret_map_next;

    // Lookups see the map as of the start of the cycle
    always_comb begin
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            src_a_preg[w] = spec_map[src_a_areg[w]];
            src_b_preg[w] = spec_map[src_b_areg[w]];
        end
    end

    // An older way committing the same register replaces the RRAT entry
    // first, so the younger way releases that way's register instead
    always_comb begin
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            released_preg[w] = ret_map[commit_areg[w]];
            for (int v = 0; v < w; v++) begin
                if (commit_valid[v] && commit_areg[v] == commit_areg[w]) begin
                    released_preg[w] = commit_preg[v];
                end
            end
        end
    end

    always_comb begin
        spec_map_next = spec_map;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (rename_valid[w] && rename_grant[w]) begin
                spec_map_next[dest_areg[w]] = alloc_preg[w];   // Younger way wins
            end
        end
    end

    always_comb begin
        ret_map_next = ret_map;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (commit_valid[w]) begin
                ret_map_next[commit_areg[w]] = commit_preg[w];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `RENAME_AREGS; a++) begin
                spec_map[a] <= rename_pkg::reset_preg(rename_pkg::areg_t'(a));
                ret_map[a]  <= rename_pkg::reset_preg(rename_pkg::areg_t'(a));
            end
        end else begin
            if (except) begin
                spec_map <= ret_map_next;   // Includes this cycle's commits
            end else begin
                spec_map <= spec_map_next;
            end
            ret_map <= ret_map_next;
        end
    end

endmodule

// File: free_list.sv
/*
 * Free list
 * Speculative and committed free vectors; hands out the lowest free
 * physical registers in way order with in-order grants
 */

`include "rename_config.svh"

module free_list (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 except,

    input  logic [`RENAME_WAYS-1:0]              rename_valid,

    input  logic [`RENAME_WAYS-1:0]              commit_valid,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] commit_preg,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] released_preg,

    output logic [`RENAME_WAYS-1:0]              rename_grant,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] alloc_preg
);

    logic [`RENAME_PREGS-1:0] spec_free;
    logic [`RENAME_PREGS-1:0] spec_free_next;
    logic [`RENAME_PREGS-1:0] comm_free;
    logic [`RENAME_PREGS-1:0] comm_free_next;

    // Each way takes the lowest register left over by the older ways.
    // A requesting way that misses its grant blocks every younger way.
    always_comb begin
        logic [`RENAME_PREGS-1:0] avail;
        logic                     in_order;
        logic                     found;

        avail    = spec_free;
        in_order = 1'b1;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            found         = 1'b0;
            alloc_preg[w] = '0;
            for (int p = `RENAME_PREGS - 1; p >= 0; p--) begin
                if (avail[p]) begin
                    found         = 1'b1;
                    alloc_preg[w] = rename_pkg::preg_t'(p);
                end
            end
            rename_grant[w] = in_order && found;
            if (rename_valid[w]) begin
                if (rename_grant[w]) begin
                    avail[alloc_preg[w]] = 1'b0;   // Taken by this way
                end else begin
                    in_order = 1'b0;
                end
            end
        end
    end

    // Way order matters when two ways commit the same register
    always_comb begin
        comm_free_next = comm_free;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (commit_valid[w]) begin
                comm_free_next[commit_preg[w]]   = 1'b0;
                comm_free_next[released_preg[w]] = 1'b1;
            end
        end
    end

    always_comb begin
        spec_free_next = spec_free;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (rename_valid[w] && rename_grant[w]) begin
                spec_free_next[alloc_preg[w]] = 1'b0;
            end
        end
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (commit_valid[w]) begin
                spec_free_next[released_preg[w]] = 1'b1;   // Usable next cycle
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `RENAME_PREGS; p++) begin
                spec_free[p] <= (p >= `RENAME_AREGS) ? 1'b1 : 1'b0;
                comm_free[p] <= (p >= `RENAME_AREGS) ? 1'b1 : 1'b0;
            end
        end else begin
            if (except) begin
                spec_free <= comm_free_next;   // Drop all speculative allocations
            end else begin
                spec_free <= spec_free_next;
            end
            comm_free <= comm_free_next;
        end
    end

endmodule

// File: ready_table.sv
/*
 * Ready table
 * One ready bit per physical register, cleared on allocation and set
 * by result bus writebacks
 */

`include "rename_config.svh"

module ready_table (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 except,

    input  logic [`RENAME_WAYS-1:0]              rename_valid,
    input  logic [`RENAME_WAYS-1:0]              rename_grant,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] alloc_preg,

    input  logic [`RENAME_WAYS-1:0]              wb_valid,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] wb_preg,

    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] src_a_preg,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] src_b_preg,

    output logic [`RENAME_WAYS-1:0]              src_a_ready,
    output logic [`RENAME_WAYS-1:0]              src_b_ready
);

    logic [`RENAME_PREGS-1:0] ready;
    logic [`RENAME_PREGS-1:0] ready_next;

    // No bypass of same-cycle writebacks, readiness shows from next cycle
    always_comb begin
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            src_a_ready[w] = ready[src_a_preg[w]];
            src_b_ready[w] = ready[src_b_preg[w]];
        end
    end

    always_comb begin
        ready_next = ready;
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (wb_valid[w]) begin
                ready_next[wb_preg[w]] = 1'b1;
            end
        end
        // Applied last so a fresh allocation wins over a writeback
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (rename_valid[w] && rename_grant[w]) begin
                ready_next[alloc_preg[w]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `RENAME_PREGS; p++) begin
                ready[p] <= (p < `RENAME_AREGS) ? 1'b1 : 1'b0;
            end
        end else if (except) begin
            ready <= '1;   // Only committed values stay mapped
        end else begin
            ready <= ready_next;
        end
    end

endmodule

// File: rename_unit.sv
/*
 * Register rename stage
 * Joins the rename map, free list and ready table into one unit
 */

`include "rename_config.svh"

module rename_unit (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 except,

    input  logic [`RENAME_WAYS-1:0]              rename_valid,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] dest_areg,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] src_a_areg,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] src_b_areg,

    input  logic [`RENAME_WAYS-1:0]              commit_valid,
    input  rename_pkg::areg_t [`RENAME_WAYS-1:0] commit_areg,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] commit_preg,

    input  logic [`RENAME_WAYS-1:0]              wb_valid,
    input  rename_pkg::preg_t [`RENAME_WAYS-1:0] wb_preg,

    output logic [`RENAME_WAYS-1:0]              rename_grant,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] rename_preg,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_a_preg,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_b_preg,
    output logic [`RENAME_WAYS-1:0]              src_a_ready,
    output logic [`RENAME_WAYS-1:0]              src_b_ready
);

    rename_pkg::preg_t [`RENAME_WAYS-1:0] alloc_preg;      // From free list
    rename_pkg::preg_t [`RENAME_WAYS-1:0] released_preg;   // Back to free list

    assign rename_preg = alloc_preg;

    rename_map u_map (
        .clock         (clock),
        .reset         (reset),
        .except        (except),
        .rename_valid  (rename_valid),
        .rename_grant  (rename_grant),
        .dest_areg     (dest_areg),
        .alloc_preg    (alloc_preg),
        .src_a_areg    (src_a_areg),
        .src_b_areg    (src_b_areg),
        .commit_valid  (commit_valid),
        .commit_areg   (commit_areg),
        .commit_preg   (commit_preg),
        .src_a_preg    (src_a_preg),
        .src_b_preg    (src_b_preg),
        .released_preg (released_preg)
    );

    free_list u_free (
        .clock         (clock),
        .reset         (reset),
        .except        (except),
        .rename_valid  (rename_valid),
        .commit_valid  (commit_valid),
        .commit_preg   (commit_preg),
        .released_preg (released_preg),
        .rename_grant  (rename_grant),
        .alloc_preg    (alloc_preg)
    );

    ready_table u_ready (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .rename_valid (rename_valid),
        .rename_grant (rename_grant),
        .alloc_preg   (alloc_preg),
        .wb_valid     (wb_valid),
        .wb_preg      (wb_preg),
        .src_a_preg   (src_a_preg),
        .src_b_preg   (src_b_preg),
        .src_a_ready  (src_a_ready),
        .src_b_ready  (src_b_ready)
    );

endmodule

// File: rename_ref.svh
/*
 * Rename reference model
 * Model tables, expected outputs, next-state update and stimulus LFSR
 */

`ifndef RENAME_REF_SVH
`define RENAME_REF_SVH

rename_pkg::preg_t        m_spec [`RENAME_AREGS];   // Speculative map
rename_pkg::preg_t        m_ret  [`RENAME_AREGS];   // Retirement map
logic [`RENAME_PREGS-1:0] m_spec_free;
logic [`RENAME_PREGS-1:0] m_comm_free;
logic [`RENAME_PREGS-1:0] m_ready;
rename_pkg::areg_t        q_areg [$];               // Renamed, not yet committed
rename_pkg::preg_t        q_preg [$];
logic [31:0]              lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] random_bits(int count);
    logic [31:0] value;
    logic        fb;

    value = '0;
    for (int i = 0; i < count; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

function automatic void reset_model();
    for (int a = 0; a < `RENAME_AREGS; a++) begin
        m_spec[a] = rename_pkg::preg_t'(a);   // Register i starts in physical i
        m_ret[a]  = rename_pkg::preg_t'(a);
    end
    for (int p = 0; p < `RENAME_PREGS; p++) begin
        m_spec_free[p] = (p >= `RENAME_AREGS);
        m_comm_free[p] = (p >= `RENAME_AREGS);
        m_ready[p]     = (p < `RENAME_AREGS);
    end
    q_areg.delete();
    q_preg.delete();
endfunction

// Expected outputs for the inputs now on the DUT ports
function automatic void expected_outputs(
    output logic [`RENAME_WAYS-1:0]              grant,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] preg,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_a,
    output rename_pkg::preg_t [`RENAME_WAYS-1:0] src_b,
    output logic [`RENAME_WAYS-1:0]              ready_a,
    output logic [`RENAME_WAYS-1:0]              ready_b
);
    logic [`RENAME_PREGS-1:0] left;
    logic                     stalled;
    logic                     found;

    left    = m_spec_free;
    stalled = 1'b0;
    for (int w = 0; w < `RENAME_WAYS; w++) begin
        found   = 1'b0;
        preg[w] = '0;
        for (int p = 0; p < `RENAME_PREGS; p++) begin
            if (!found && left[p]) begin
                found   = 1'b1;
                preg[w] = rename_pkg::preg_t'(p);   // Lowest free first
            end
        end
        grant[w] = found && !stalled;
        if (rename_valid[w] && grant[w]) begin
            left[preg[w]] = 1'b0;
        end else if (rename_valid[w]) begin
            stalled = 1'b1;   // Younger ways wait behind this one
        end
        src_a[w]   = m_spec[src_a_areg[w]];
        src_b[w]   = m_spec[src_b_areg[w]];
        ready_a[w] = m_ready[src_a[w]];
        ready_b[w] = m_ready[src_b[w]];
    end
endfunction

function automatic void advance_model(
    input logic [`RENAME_WAYS-1:0]              grant,
    input rename_pkg::preg_t [`RENAME_WAYS-1:0] preg
);
    rename_pkg::preg_t        ret_next [`RENAME_AREGS];
    logic [`RENAME_PREGS-1:0] comm_next;
    rename_pkg::preg_t        released;

    ret_next  = m_ret;
    comm_next = m_comm_free;
    // Walking ways in order hands an older commit to a younger one
    for (int w = 0; w < `RENAME_WAYS; w++) begin
        if (commit_valid[w]) begin
            released                  = ret_next[commit_areg[w]];
            ret_next[commit_areg[w]]  = commit_preg[w];
            comm_next[commit_preg[w]] = 1'b0;
            comm_next[released]       = 1'b1;
            m_spec_free[released]     = 1'b1;
            void'(q_areg.pop_front());
            void'(q_preg.pop_front());
        end
    end
    for (int w = 0; w < `RENAME_WAYS; w++) begin
        if (wb_valid[w]) begin
            m_ready[wb_preg[w]] = 1'b1;
        end
    end
    if (except) begin
        m_spec      = ret_next;
        m_spec_free = comm_next;
        m_ready     = '1;
        q_areg.delete();   // Everything in flight is squashed
        q_preg.delete();
    end else begin
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (rename_valid[w] && grant[w]) begin
                m_spec[dest_areg[w]] = preg[w];
                m_spec_free[preg[w]] = 1'b0;
                m_ready[preg[w]]     = 1'b0;
                q_areg.push_back(dest_areg[w]);
                q_preg.push_back(preg[w]);
            end
        end
    end
    m_ret       = ret_next;
    m_comm_free = comm_next;
endfunction

`endif

// File: rename_tb.sv
/*
 * Rename stage testbench
 * Random rename, commit, writeback and exception traffic, checked
 * against a reference model on every cycle
 */

`include "rename_config.svh"

module rename_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 2500;   // Reset plus run, with margin
    localparam int PHASE_CYCLES   = 300;    // Fill half, then drain half

    logic                                 clock;
    logic                                 reset;
    logic                                 except;
    logic [`RENAME_WAYS-1:0]              rename_valid;
    rename_pkg::areg_t [`RENAME_WAYS-1:0] dest_areg;
    rename_pkg::areg_t [`RENAME_WAYS-1:0] src_a_areg;
    rename_pkg::areg_t [`RENAME_WAYS-1:0] src_b_areg;
    logic [`RENAME_WAYS-1:0]              commit_valid;
    rename_pkg::areg_t [`RENAME_WAYS-1:0] commit_areg;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] commit_preg;
    logic [`RENAME_WAYS-1:0]              wb_valid;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] wb_preg;
    logic [`RENAME_WAYS-1:0]              rename_grant;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] rename_preg;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] src_a_preg;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] src_b_preg;
    logic [`RENAME_WAYS-1:0]              src_a_ready;
    logic [`RENAME_WAYS-1:0]              src_b_ready;

    logic [`RENAME_WAYS-1:0]              exp_grant;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] exp_preg;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] exp_src_a;
    rename_pkg::preg_t [`RENAME_WAYS-1:0] exp_src_b;
    logic [`RENAME_WAYS-1:0]              exp_ready_a;
    logic [`RENAME_WAYS-1:0]              exp_ready_b;

    logic checking;
    int   cycle_count;
    int   denied_count;    // Requests turned away by an empty free list
    int   except_count;
    int   forward_count;   // Two ways committing one register

    `include "rename_ref.svh"

    rename_unit dut (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .rename_valid (rename_valid),
        .dest_areg    (dest_areg),
        .src_a_areg   (src_a_areg),
        .src_b_areg   (src_b_areg),
        .commit_valid (commit_valid),
        .commit_areg  (commit_areg),
        .commit_preg  (commit_preg),
        .wb_valid     (wb_valid),
        .wb_preg      (wb_preg),
        .rename_grant (rename_grant),
        .rename_preg  (rename_preg),
        .src_a_preg   (src_a_preg),
        .src_b_preg   (src_b_preg),
        .src_a_ready  (src_a_ready),
        .src_b_ready  (src_b_ready)
    );

    always #20 clock = ~clock;

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(string what, int way, int got, int want);
        if (got != want) begin
            fail_run($sformatf("Fail at time %0t: %s on way %0d is %0d, expected %0d",
                               $time, what, way, got, want));
        end
    endtask

    task automatic drive_idle();
        except       = 1'b0;
        rename_valid = '0;
        dest_areg    = '0;
        src_a_areg   = '0;
        src_b_areg   = '0;
        commit_valid = '0;
        commit_areg  = '0;
        commit_preg  = '0;
        wb_valid     = '0;
        wb_preg      = '0;
    endtask

    task automatic drive_traffic(bit fill);
        int idx;

        except = (random_bits(7) == 0);
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            rename_valid[w] = (random_bits(2) != 0);
            if (random_bits(2) == 0) begin
                dest_areg[w] = rename_pkg::areg_t'(random_bits(2));   // Crowd a few registers
            end else begin
                dest_areg[w] = rename_pkg::areg_t'(random_bits(5));
            end
            src_a_areg[w] = rename_pkg::areg_t'(random_bits(5));
            src_b_areg[w] = rename_pkg::areg_t'(random_bits(5));
        end
        for (int w = 0; w < `RENAME_WAYS; w++) begin
            if (fill) begin
                commit_valid[w] = (random_bits(3) == 0);
            end else begin
                commit_valid[w] = (random_bits(2) != 0);
            end
            // Oldest in flight first, with no gap between ways
            if (w >= q_areg.size() || (w > 0 && !commit_valid[w-1])) begin
                commit_valid[w] = 1'b0;
            end
            commit_areg[w] = '0;
            commit_preg[w] = '0;
            if (commit_valid[w]) begin
                commit_areg[w] = q_areg[w];
                commit_preg[w] = q_preg[w];
            end
            wb_valid[w] = (q_preg.size() > 0) && (random_bits(1) == 1);
            wb_preg[w]  = '0;
            if (wb_valid[w]) begin
                idx        = int'(random_bits(5)) % q_preg.size();
                wb_preg[w] = q_preg[idx];
            end
        end
    endtask

    // Compare against the model, then let the model take the edge
    always @(posedge clock) begin
        if (checking) begin
            expected_outputs(exp_grant, exp_preg, exp_src_a, exp_src_b,
                             exp_ready_a, exp_ready_b);
            for (int w = 0; w < `RENAME_WAYS; w++) begin
                check("src_a_preg", w, int'(src_a_preg[w]), int'(exp_src_a[w]));
                check("src_b_preg", w, int'(src_b_preg[w]), int'(exp_src_b[w]));
                check("src_a_ready", w, int'(src_a_ready[w]), int'(exp_ready_a[w]));
                check("src_b_ready", w, int'(src_b_ready[w]), int'(exp_ready_b[w]));
                if (rename_valid[w]) begin
                    check("rename_grant", w, int'(rename_grant[w]), int'(exp_grant[w]));
                    if (exp_grant[w]) begin
                        check("rename_preg", w, int'(rename_preg[w]), int'(exp_preg[w]));
                    end else begin
                        denied_count++;
                    end
                end
                for (int v = 0; v < w; v++) begin
                    if (commit_valid[v] && commit_valid[w] && commit_areg[v] == commit_areg[w]) begin
                        forward_count++;
                    end
                end
            end
            if (except) begin
                except_count++;
            end
            advance_model(exp_grant, exp_preg);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_count));
        end
    end

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        checking      = 1'b0;
        cycle_count   = 0;
        denied_count  = 0;
        except_count  = 0;
        forward_count = 0;
        lfsr_state    = 32'haf07_04c6;
        drive_idle();
        reset_model();
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset    = 1'b0;
        checking = 1'b1;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            drive_traffic((c % PHASE_CYCLES) < PHASE_CYCLES / 2);
            @(negedge clock);
        end
        checking = 1'b0;
        drive_idle();
        if (denied_count == 0 || except_count == 0 || forward_count == 0) begin
            fail_run($sformatf("Traffic missed a case: %0d stalls, %0d exceptions, %0d forwards",
                               denied_count, except_count, forward_count));
        end else begin
            $display("Stalled requests %0d, exceptions %0d, forwarded commits %0d",
                     denied_count, except_count, forward_count);
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+.
rename_pkg.sv
rename_map.sv
free_list.sv
ready_table.sv
rename_unit.sv
rename_tb.sv

// File: Makefile
# Verilator build and run of the rename stage testbench

sim:
	rm -f sim.log
	verilator --binary --timing -j 0 -f all.f --top-module rename_tb -Mdir obj_dir
	-./obj_dir/Vrename_tb > sim.log 2>&1
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
